// ==== verilog/ooo_pkg.sv ====
package ooo_pkg;

    localparam int xlen      = 32;
    localparam int num_regs  = 8;
    localparam int reg_idx_w = 3;
    localparam int rob_depth = 8;
    localparam int tag_w     = 3;
    localparam int rs_depth  = 4;
    localparam int op_w      = 3;

    // opcodes as sent by the front end
    localparam logic [op_w-1:0] op_add  = 3'd0;
    localparam logic [op_w-1:0] op_sub  = 3'd1;
    localparam logic [op_w-1:0] op_xor  = 3'd2;
    localparam logic [op_w-1:0] op_addi = 3'd3;
    localparam logic [op_w-1:0] op_beq  = 3'd4;
    localparam logic [op_w-1:0] op_bne  = 3'd5;
    localparam logic [op_w-1:0] op_sw   = 3'd6;

    // what a reorder-buffer entry does at retirement
    localparam int kind_w = 2;
    localparam logic [kind_w-1:0] kind_alu = 2'd0;
    localparam logic [kind_w-1:0] kind_st  = 2'd1;
    localparam logic [kind_w-1:0] kind_br  = 2'd2;

    // second word of an entry, meaning depends on kind
    typedef union packed {
        logic [xlen-1:0] jump_target;
        logic [xlen-1:0] store_addr;
    } entry_aux_t;

endpackage

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/1ns

module reorder_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [ooo_pkg::op_w-1:0]      instr_op,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rd,
    input  logic [ooo_pkg::xlen-1:0]      instr_pc,
    input  logic                          instr_pred_taken,
    output logic [ooo_pkg::tag_w-1:0]     alloc_tag,
    input  logic [ooo_pkg::tag_w-1:0]     rd_tag1,
    input  logic [ooo_pkg::tag_w-1:0]     rd_tag2,
    output logic                          fwd_valid1,
    output logic [ooo_pkg::xlen-1:0]      fwd_data1,
    output logic                          fwd_valid2,
    output logic [ooo_pkg::xlen-1:0]      fwd_data2,
    input  logic                          res_valid,
    input  logic [ooo_pkg::tag_w-1:0]     res_tag,
    input  logic [ooo_pkg::xlen-1:0]      res_data,
    input  ooo_pkg::entry_aux_t           res_aux,
    input  logic                          res_taken,
    output logic                          commit_valid,
    output logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    output logic [ooo_pkg::tag_w-1:0]     commit_tag,
    output logic [ooo_pkg::xlen-1:0]      commit_data,
    output logic                          mem_we,
    output logic [ooo_pkg::xlen-1:0]      mem_addr,
    output logic [ooo_pkg::xlen-1:0]      mem_wdata,
    output logic                          credit_return,
    output logic                          flush,
    output logic [ooo_pkg::xlen-1:0]      redirect_pc
);

    logic [ooo_pkg::tag_w-1:0]     head;
    logic [ooo_pkg::tag_w-1:0]     tail;
    logic [ooo_pkg::tag_w:0]       count;
    logic [ooo_pkg::rob_depth-1:0] done;

    logic [ooo_pkg::kind_w-1:0]    kind  [ooo_pkg::rob_depth];
    logic [ooo_pkg::reg_idx_w-1:0] dest  [ooo_pkg::rob_depth];
    logic                          pred  [ooo_pkg::rob_depth];
    logic                          taken [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      pc    [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      data  [ooo_pkg::rob_depth];
    ooo_pkg::entry_aux_t           aux   [ooo_pkg::rob_depth];

    logic                          retire;
    logic [ooo_pkg::kind_w-1:0]    dsp_kind;
    logic [ooo_pkg::tag_w-1:0]     res_age;

    assign alloc_tag  = tail;
    assign fwd_valid1 = done[rd_tag1];
    assign fwd_data1  = data[rd_tag1];
    assign fwd_valid2 = done[rd_tag2];
    assign fwd_data2  = data[rd_tag2];

    // nothing retires behind a pending flush
    assign retire  = !flush && (count != '0) && done[head];
    assign res_age = res_tag - head;

    always_comb begin
        case (instr_op)
            ooo_pkg::op_sw:                   dsp_kind = ooo_pkg::kind_st;
            ooo_pkg::op_beq, ooo_pkg::op_bne: dsp_kind = ooo_pkg::kind_br;
            default:                          dsp_kind = ooo_pkg::kind_alu;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            done          <= '0;
            commit_valid  <= 1'b0;
            mem_we        <= 1'b0;
            credit_return <= 1'b0;
            flush         <= 1'b0;
        end else begin
            commit_valid  <= retire && (kind[head] == ooo_pkg::kind_alu);
            mem_we        <= retire && (kind[head] == ooo_pkg::kind_st);
            flush         <= retire && (kind[head] == ooo_pkg::kind_br)
                             && (taken[head] != pred[head]);
            credit_return <= retire;
            if (instr_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + ooo_pkg::tag_w'(1);
            end
            if (res_valid) begin
                done[res_tag] <= 1'b1;
            end
            if (retire) begin
                done[head] <= 1'b0;
                head       <= head + ooo_pkg::tag_w'(1);
            end
            count <= count + (ooo_pkg::tag_w + 1)'(instr_valid)
                           - (ooo_pkg::tag_w + 1)'(retire);
        end
    end

    // entry payload and commit fields, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            kind[tail] <= dsp_kind;
            dest[tail] <= instr_rd;
            pred[tail] <= instr_pred_taken;
            pc[tail]   <= instr_pc;
        end
        if (res_valid) begin
            data[res_tag]  <= res_data;
            aux[res_tag]   <= res_aux;
            taken[res_tag] <= res_taken;
        end
        commit_rd   <= dest[head];
        commit_tag  <= head;
        commit_data <= data[head];
        mem_addr    <= aux[head].store_addr;
        mem_wdata   <= data[head];
        redirect_pc <= taken[head] ? aux[head].jump_target
                                   : pc[head] + ooo_pkg::xlen'(4);
    end

    // credits at the front end must keep the buffer from overflowing
    a_alloc_not_full: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> count != (ooo_pkg::tag_w + 1)'(ooo_pkg::rob_depth));

    // results come back once, and only for live entries
    a_result_live: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> ({1'b0, res_age} < count) && !done[res_tag]);

endmodule

// ==== verilog/reg_status.sv ====
`timescale 1ns/1ns

module reg_status (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [ooo_pkg::op_w-1:0]      instr_op,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rd,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rs1,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rs2,
    input  logic [ooo_pkg::tag_w-1:0]     alloc_tag,
    input  logic                          commit_valid,
    input  logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    input  logic [ooo_pkg::tag_w-1:0]     commit_tag,
    input  logic [ooo_pkg::xlen-1:0]      commit_data,
    input  logic                          flush,
    output logic                          src1_pending,
    output logic [ooo_pkg::tag_w-1:0]     src1_tag,
    output logic [ooo_pkg::xlen-1:0]      src1_value,
    output logic                          src2_pending,
    output logic [ooo_pkg::tag_w-1:0]     src2_tag,
    output logic [ooo_pkg::xlen-1:0]      src2_value
);

    logic [ooo_pkg::xlen-1:0]     regs [ooo_pkg::num_regs];
    logic [ooo_pkg::tag_w-1:0]    ptag [ooo_pkg::num_regs];
    logic [ooo_pkg::num_regs-1:0] pend;
    logic                         renames;

    // stores and branches have no destination
    assign renames = instr_valid && (instr_rd != '0)
                     && (instr_op != ooo_pkg::op_sw)
                     && (instr_op != ooo_pkg::op_beq)
                     && (instr_op != ooo_pkg::op_bne);

    // committing tag still owns the register
    function automatic logic commit_clears(input logic [ooo_pkg::reg_idx_w-1:0] idx);
        return commit_valid && (commit_rd == idx) && (ptag[idx] == commit_tag);
    endfunction

    function automatic logic [ooo_pkg::xlen-1:0] read_reg(
        input logic [ooo_pkg::reg_idx_w-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        if (commit_valid && (commit_rd == idx)) begin
            return commit_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        src1_pending = pend[instr_rs1] && !commit_clears(instr_rs1);
        src1_tag     = ptag[instr_rs1];
        src1_value   = read_reg(instr_rs1);
        src2_pending = pend[instr_rs2] && !commit_clears(instr_rs2);
        src2_tag     = ptag[instr_rs2];
        src2_value   = read_reg(instr_rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
            pend <= '0;
        end else begin
            if (commit_valid && (commit_rd != '0)) begin
                regs[commit_rd] <= commit_data;
                if (ptag[commit_rd] == commit_tag) begin
                    pend[commit_rd] <= 1'b0;
                end
            end
            // a new rename wins over a same-cycle commit
            if (flush) begin
                pend <= '0;
            end else if (renames) begin
                pend[instr_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (renames) begin
            ptag[instr_rd] <= alloc_tag;
        end
    end

endmodule

// ==== verilog/res_station.sv ====
`timescale 1ns/1ns

module res_station (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      instr_valid,
    input  logic [ooo_pkg::op_w-1:0]  instr_op,
    input  logic [ooo_pkg::xlen-1:0]  instr_imm,
    input  logic [ooo_pkg::xlen-1:0]  instr_pc,
    input  logic [ooo_pkg::xlen-1:0]  instr_target,
    input  logic [ooo_pkg::tag_w-1:0] alloc_tag,
    input  logic                      src1_pending,
    input  logic [ooo_pkg::tag_w-1:0] src1_tag,
    input  logic [ooo_pkg::xlen-1:0]  src1_value,
    input  logic                      src2_pending,
    input  logic [ooo_pkg::tag_w-1:0] src2_tag,
    input  logic [ooo_pkg::xlen-1:0]  src2_value,
    input  logic                      fwd_valid1,
    input  logic [ooo_pkg::xlen-1:0]  fwd_data1,
    input  logic                      fwd_valid2,
    input  logic [ooo_pkg::xlen-1:0]  fwd_data2,
    input  logic                      res_valid,
    input  logic [ooo_pkg::tag_w-1:0] res_tag,
    input  logic [ooo_pkg::xlen-1:0]  res_data,
    output logic                      issue_valid,
    output logic [ooo_pkg::op_w-1:0]  issue_op,
    output logic [ooo_pkg::tag_w-1:0] issue_tag,
    output logic [ooo_pkg::xlen-1:0]  issue_a,
    output logic [ooo_pkg::xlen-1:0]  issue_b,
    output logic [ooo_pkg::xlen-1:0]  issue_imm,
    output logic [ooo_pkg::xlen-1:0]  issue_pc,
    output logic [ooo_pkg::xlen-1:0]  issue_target
);

    // one slot per tag, so the slot index is the tag
    logic [ooo_pkg::rob_depth-1:0] valid;
    logic [ooo_pkg::op_w-1:0]      op     [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      imm    [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      pc     [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      target [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]      opnd   [ooo_pkg::rob_depth][2];
    logic [ooo_pkg::tag_w-1:0]     wtag   [ooo_pkg::rob_depth][2];
    logic [1:0]                    rdy    [ooo_pkg::rob_depth];

    logic                          d_pend [2];
    logic [ooo_pkg::tag_w-1:0]     d_tag  [2];
    logic [ooo_pkg::xlen-1:0]      d_val  [2];
    logic                          d_fwd  [2];
    logic [ooo_pkg::xlen-1:0]      d_fdat [2];
    logic                          d_rdy  [2];
    logic [ooo_pkg::xlen-1:0]      d_opnd [2];
    logic [ooo_pkg::tag_w-1:0]     scan;
    logic [ooo_pkg::tag_w-1:0]     sel;
    logic                          found;

    // operand source at dispatch: register file, then buffer, then bus
    always_comb begin
        d_pend = '{src1_pending, src2_pending};
        d_tag  = '{src1_tag, src2_tag};
        d_val  = '{src1_value, src2_value};
        d_fwd  = '{fwd_valid1, fwd_valid2};
        d_fdat = '{fwd_data1, fwd_data2};
        for (int s = 0; s < 2; s++) begin
            d_rdy[s]  = 1'b1;
            d_opnd[s] = d_val[s];
            if (d_pend[s]) begin
                if (d_fwd[s]) begin
                    d_opnd[s] = d_fdat[s];
                end else if (res_valid && (res_tag == d_tag[s])) begin
                    d_opnd[s] = res_data;
                end else begin
                    d_rdy[s] = 1'b0;
                end
            end
        end
    end

    // oldest first, scanning from the tail tag around the ring
    always_comb begin
        found = 1'b0;
        sel   = alloc_tag;
        scan  = alloc_tag;
        for (int k = 0; k < ooo_pkg::rob_depth; k++) begin
            scan = alloc_tag + ooo_pkg::tag_w'(k);
            if (!found && valid[scan] && (&rdy[scan])) begin
                found = 1'b1;
                sel   = scan;
            end
        end
    end

    assign issue_valid  = found;
    assign issue_tag    = sel;
    assign issue_op     = op[sel];
    assign issue_a      = opnd[sel][0];
    assign issue_b      = opnd[sel][1];
    assign issue_imm    = imm[sel];
    assign issue_pc     = pc[sel];
    assign issue_target = target[sel];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else begin
            if (found) begin
                valid[sel] <= 1'b0;
            end
            if (instr_valid) begin
                valid[alloc_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            op[alloc_tag]     <= instr_op;
            imm[alloc_tag]    <= instr_imm;
            pc[alloc_tag]     <= instr_pc;
            target[alloc_tag] <= instr_target;
            for (int s = 0; s < 2; s++) begin
                opnd[alloc_tag][s] <= d_opnd[s];
                wtag[alloc_tag][s] <= d_tag[s];
                rdy[alloc_tag][s]  <= d_rdy[s];
            end
        end
        // wake waiting operands from the result bus
        for (int e = 0; e < ooo_pkg::rob_depth; e++) begin
            for (int s = 0; s < 2; s++) begin
                if (valid[e] && !rdy[e][s] && res_valid && (res_tag == wtag[e][s])) begin
                    opnd[e][s] <= res_data;
                    rdy[e][s]  <= 1'b1;
                end
            end
        end
    end

    a_accept_free_slot: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> !valid[alloc_tag]);

endmodule

// ==== verilog/alu_pipe.sv ====
`timescale 1ns/1ns

module alu_pipe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      issue_valid,
    input  logic [ooo_pkg::op_w-1:0]  issue_op,
    input  logic [ooo_pkg::tag_w-1:0] issue_tag,
    input  logic [ooo_pkg::xlen-1:0]  issue_a,
    input  logic [ooo_pkg::xlen-1:0]  issue_b,
    input  logic [ooo_pkg::xlen-1:0]  issue_imm,
    input  logic [ooo_pkg::xlen-1:0]  issue_pc,
    input  logic [ooo_pkg::xlen-1:0]  issue_target,
    output logic                      res_valid,
    output logic [ooo_pkg::tag_w-1:0] res_tag,
    output logic [ooo_pkg::xlen-1:0]  res_data,
    output ooo_pkg::entry_aux_t       res_aux,
    output logic                      res_taken
);

    logic                      s1_valid;
    logic [ooo_pkg::op_w-1:0]  s1_op;
    logic [ooo_pkg::tag_w-1:0] s1_tag;
    logic [ooo_pkg::xlen-1:0]  s1_a;
    logic [ooo_pkg::xlen-1:0]  s1_b;
    logic [ooo_pkg::xlen-1:0]  s1_imm;
    logic [ooo_pkg::xlen-1:0]  s1_pc;
    logic [ooo_pkg::xlen-1:0]  s1_target;

    logic [ooo_pkg::xlen-1:0]  s1_data;
    ooo_pkg::entry_aux_t       s1_aux;
    logic                      s1_taken;

    always_comb begin
        s1_data            = s1_a + s1_b;
        s1_aux.jump_target = s1_target;
        s1_taken           = 1'b0;
        case (s1_op)
            ooo_pkg::op_sub:  s1_data = s1_a - s1_b;
            ooo_pkg::op_xor:  s1_data = s1_a ^ s1_b;
            ooo_pkg::op_addi: s1_data = s1_a + s1_imm;
            ooo_pkg::op_beq, ooo_pkg::op_bne: begin
                s1_taken = (s1_a == s1_b) ^ (s1_op == ooo_pkg::op_bne);
            end
            ooo_pkg::op_sw: begin
                s1_data           = s1_b;
                s1_aux.store_addr = s1_a + s1_imm;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= issue_op;
        s1_tag    <= issue_tag;
        s1_a      <= issue_a;
        s1_b      <= issue_b;
        s1_imm    <= issue_imm;
        s1_pc     <= issue_pc;
        s1_target <= issue_target;
        res_tag   <= s1_tag;
        res_data  <= s1_data;
        res_aux   <= s1_aux;
        res_taken <= s1_taken;
    end

endmodule

// ==== verilog/ooo_backend_top.sv ====
`timescale 1ns/1ns

module ooo_backend_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  logic [ooo_pkg::op_w-1:0]      instr_op,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rd,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rs1,
    input  logic [ooo_pkg::reg_idx_w-1:0] instr_rs2,
    input  logic [ooo_pkg::xlen-1:0]      instr_imm,
    input  logic [ooo_pkg::xlen-1:0]      instr_pc,
    input  logic                          instr_pred_taken,
    input  logic [ooo_pkg::xlen-1:0]      instr_target,
    output logic                          credit_return,
    output logic                          commit_valid,
    output logic [ooo_pkg::reg_idx_w-1:0] commit_rd,
    output logic [ooo_pkg::xlen-1:0]      commit_data,
    output logic                          mem_we,
    output logic [ooo_pkg::xlen-1:0]      mem_addr,
    output logic [ooo_pkg::xlen-1:0]      mem_wdata,
    output logic                          flush,
    output logic [ooo_pkg::xlen-1:0]      redirect_pc
);

    logic [ooo_pkg::tag_w-1:0] alloc_tag;
    logic [ooo_pkg::tag_w-1:0] commit_tag;

    logic                      src1_pending;
    logic [ooo_pkg::tag_w-1:0] src1_tag;
    logic [ooo_pkg::xlen-1:0]  src1_value;
    logic                      src2_pending;
    logic [ooo_pkg::tag_w-1:0] src2_tag;
    logic [ooo_pkg::xlen-1:0]  src2_value;
    logic                      fwd_valid1;
    logic [ooo_pkg::xlen-1:0]  fwd_data1;
    logic                      fwd_valid2;
    logic [ooo_pkg::xlen-1:0]  fwd_data2;

    logic                      issue_valid;
    logic [ooo_pkg::op_w-1:0]  issue_op;
    logic [ooo_pkg::tag_w-1:0] issue_tag;
    logic [ooo_pkg::xlen-1:0]  issue_a;
    logic [ooo_pkg::xlen-1:0]  issue_b;
    logic [ooo_pkg::xlen-1:0]  issue_imm;
    logic [ooo_pkg::xlen-1:0]  issue_pc;
    logic [ooo_pkg::xlen-1:0]  issue_target;

    // result bus
    logic                      res_valid;
    logic [ooo_pkg::tag_w-1:0] res_tag;
    logic [ooo_pkg::xlen-1:0]  res_data;
    ooo_pkg::entry_aux_t       res_aux;
    logic                      res_taken;

    reorder_buffer u_reorder_buffer (
        .*,
        .rd_tag1 (src1_tag),
        .rd_tag2 (src2_tag)
    );

    reg_status u_reg_status (.*);

    res_station u_res_station (.*);

    alu_pipe u_alu_pipe (.*);

endmodule

// ==== tests/tb_ooo_backend.sv ====
`timescale 1ns/1ns

module tb_ooo_backend;

    localparam int num_cycles  = 3000;
    localparam int idle_cycles = 6;
    localparam int drain_limit = 300;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          instr_valid;
    logic [ooo_pkg::op_w-1:0]      instr_op;
    logic [ooo_pkg::reg_idx_w-1:0] instr_rd;
    logic [ooo_pkg::reg_idx_w-1:0] instr_rs1;
    logic [ooo_pkg::reg_idx_w-1:0] instr_rs2;
    logic [ooo_pkg::xlen-1:0]      instr_imm;
    logic [ooo_pkg::xlen-1:0]      instr_pc;
    logic                          instr_pred_taken;
    logic [ooo_pkg::xlen-1:0]      instr_target;
    logic                          credit_return;
    logic                          commit_valid;
    logic [ooo_pkg::reg_idx_w-1:0] commit_rd;
    logic [ooo_pkg::xlen-1:0]      commit_data;
    logic                          mem_we;
    logic [ooo_pkg::xlen-1:0]      mem_addr;
    logic [ooo_pkg::xlen-1:0]      mem_wdata;
    logic                          flush;
    logic [ooo_pkg::xlen-1:0]      redirect_pc;

    // architectural state in program order, and what must retire next
    logic [ooo_pkg::xlen-1:0]      model_regs [ooo_pkg::num_regs];
    logic [ooo_pkg::kind_w-1:0]    exp_kind   [$];
    logic [ooo_pkg::reg_idx_w-1:0] exp_rd     [$];
    logic [ooo_pkg::xlen-1:0]      exp_data   [$];
    logic [ooo_pkg::xlen-1:0]      exp_addr   [$];
    logic                          exp_flush  [$];

    int                            credits;
    int                            checks;
    int                            value_errors;
    int                            other_errors;
    int                            waited;
    int                            seed;
    logic                          started;
    logic                          wrong_path;
    logic                          quiet;
    logic [ooo_pkg::xlen-1:0]      next_pc;
    logic [ooo_pkg::xlen-1:0]      resume_pc;

    ooo_backend_top u_ooo_backend_top (.*);

    always #20 clk = ~clk;

    task automatic compare_value(input string name, input logic [ooo_pkg::xlen-1:0] exp,
                                 input logic [ooo_pkg::xlen-1:0] act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            other_errors++;
            $display("Error: %s", what);
        end
    endtask

    task automatic queue_retire(input logic [ooo_pkg::kind_w-1:0] kind,
                                input logic [ooo_pkg::reg_idx_w-1:0] rd,
                                input logic [ooo_pkg::xlen-1:0] data,
                                input logic [ooo_pkg::xlen-1:0] addr, input logic mis);
        exp_kind.push_back(kind);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_addr.push_back(addr);
        exp_flush.push_back(mis);
    endtask

    task automatic model_alu(input logic [ooo_pkg::xlen-1:0] result);
        queue_retire(ooo_pkg::kind_alu, instr_rd, result, '0, 1'b0);
        if (instr_rd != '0) begin
            model_regs[instr_rd] = result;
        end
    endtask

    task automatic dispatch_random();
        logic [ooo_pkg::xlen-1:0] a;
        logic [ooo_pkg::xlen-1:0] b;
        logic [ooo_pkg::xlen-1:0] fall_pc;
        logic                     is_branch;
        logic                     taken;
        instr_valid  = 1'b1;
        instr_op     = ooo_pkg::op_w'($urandom_range(6, 0));
        instr_rd     = ooo_pkg::reg_idx_w'($urandom_range(7, 0));
        instr_rs1    = ooo_pkg::reg_idx_w'($urandom_range(7, 0));
        instr_rs2    = ooo_pkg::reg_idx_w'($urandom_range(7, 0));
        instr_imm    = $urandom();
        instr_pc     = next_pc;
        instr_target = $urandom_range(16383, 0) << 2;
        a            = model_regs[instr_rs1];
        b            = model_regs[instr_rs2];
        fall_pc      = next_pc + 32'd4;
        is_branch    = (instr_op == ooo_pkg::op_beq) || (instr_op == ooo_pkg::op_bne);
        taken        = (instr_op == ooo_pkg::op_beq) ? (a == b) : (a != b);
        // predictor is right about three times in four
        instr_pred_taken = is_branch && (taken ^ ($urandom_range(3, 0) == 0));
        next_pc = instr_pred_taken ? instr_target : fall_pc;
        // wrong-path work gets flushed and never retires
        if (!wrong_path) begin
            case (instr_op)
                ooo_pkg::op_add:  model_alu(a + b);
                ooo_pkg::op_sub:  model_alu(a - b);
                ooo_pkg::op_xor:  model_alu(a ^ b);
                ooo_pkg::op_addi: model_alu(a + instr_imm);
                ooo_pkg::op_sw:   queue_retire(ooo_pkg::kind_st, '0, b, a + instr_imm, 1'b0);
                default: begin
                    resume_pc = taken ? instr_target : fall_pc;
                    wrong_path = (taken != instr_pred_taken);
                    queue_retire(ooo_pkg::kind_br, '0, '0, resume_pc, wrong_path);
                end
            endcase
        end
    endtask

    task automatic check_outputs();
        logic [ooo_pkg::kind_w-1:0] kind;
        logic                       mis;
        if (!started || quiet) begin
            require(!(commit_valid || mem_we || flush || credit_return),
                    "back end retired something with nothing outstanding");
        end
        if (!credit_return) begin
            require(!(commit_valid || mem_we || flush), "retirement strobe without a credit");
        end else if (exp_kind.size() == 0) begin
            require(1'b0, "credit returned with no instruction outstanding");
        end else begin
            kind = exp_kind.pop_front();
            mis  = exp_flush.pop_front();
            compare_value("commit_valid", ooo_pkg::xlen'(kind == ooo_pkg::kind_alu),
                          ooo_pkg::xlen'(commit_valid));
            compare_value("mem_we", ooo_pkg::xlen'(kind == ooo_pkg::kind_st),
                          ooo_pkg::xlen'(mem_we));
            compare_value("flush", ooo_pkg::xlen'(mis), ooo_pkg::xlen'(flush));
            if (kind == ooo_pkg::kind_alu) begin
                compare_value("commit_rd", ooo_pkg::xlen'(exp_rd[0]), ooo_pkg::xlen'(commit_rd));
                compare_value("commit_data", exp_data[0], commit_data);
            end
            if (kind == ooo_pkg::kind_st) begin
                compare_value("mem_addr", exp_addr[0], mem_addr);
                compare_value("mem_wdata", exp_data[0], mem_wdata);
            end
            if (mis) begin
                compare_value("redirect_pc", exp_addr[0], redirect_pc);
            end
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_addr.pop_front());
        end
    endtask

    task automatic step_cycle(input logic allow_dispatch);
        check_outputs();
        if (flush) begin
            credits    = ooo_pkg::rob_depth;
            wrong_path = 1'b0;
            quiet      = 1'b1;
            next_pc    = resume_pc;
        end else if (credit_return) begin
            credits++;
        end
        require(credits >= 0 && credits <= ooo_pkg::rob_depth, "credit count out of range");
        if (allow_dispatch && !flush && credits > 0 && $urandom_range(9, 0) < 8) begin
            dispatch_random();
            credits--;
            started = 1'b1;
            quiet   = 1'b0;
        end else begin
            instr_valid = 1'b0;
        end
    endtask

    initial begin
        seed = 91769;
        void'($urandom(seed));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr_op = '0;
        instr_rd = '0;
        instr_rs1 = '0;
        instr_rs2 = '0;
        instr_imm = '0;
        instr_pc = '0;
        instr_pred_taken = 1'b0;
        instr_target = '0;
        for (int r = 0; r < ooo_pkg::num_regs; r++) begin
            model_regs[r] = '0;
        end
        credits = ooo_pkg::rob_depth;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        started = 1'b0;
        wrong_path = 1'b0;
        quiet = 1'b0;
        next_pc = 32'h100;
        resume_pc = 32'h100;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < num_cycles; c++) begin
            @(negedge clk);
            step_cycle(c >= idle_cycles);
        end
        waited = 0;
        while (exp_kind.size() != 0 && waited < drain_limit) begin
            @(negedge clk);
            step_cycle(1'b0);
            waited++;
        end
        require(exp_kind.size() == 0, "timed out waiting for the back end to drain");
        // nothing may retire once the model is empty
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            step_cycle(1'b0);
        end
        compare_value("final_credits", ooo_pkg::rob_depth, credits);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/ooo_pkg.sv
verilog/reorder_buffer.sv
verilog/reg_status.sv
verilog/res_station.sv
verilog/alu_pipe.sv
verilog/ooo_backend_top.sv
tests/tb_ooo_backend.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := tb_ooo_backend
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TESTBENCH FAILED
PASS_MSG   := TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
